// ==== all.f ====
verilog/rs_pkg.sv
verilog/issue_if.sv
verilog/rs.sv
verilog/exec_ctrl.sv
verilog/alu_unit.sv
verilog/mult_timer.sv
verilog/mult_unit.sv
verilog/tomasulo_top.sv
verif/tb_tomasulo.sv

// ==== verif/tb_tomasulo.sv ====
// Testbench with directed and random dispatch, a tag and value
// reference model, concurrent CDB checks and a timeout
`timescale 1ns/1ps

module tb_tomasulo;

    logic                      clock;
    logic                      reset;
    logic                      squash;
    logic                      dispatch_valid;
    rs_pkg::fu_kind_t          fu_sel;
    rs_pkg::alu_op_t           op;
    logic                      src1_ready, src2_ready;
    logic [rs_pkg::TAG_W-1:0]  src1_tag, src2_tag, dest_tag;
    logic [rs_pkg::XLEN-1:0]   src1_value, src2_value;
    logic                      alu_avail, mult_avail;
    logic                      cdb_valid;
    logic [rs_pkg::TAG_W-1:0]  cdb_tag;
    logic [rs_pkg::XLEN-1:0]   cdb_value;

    logic [15:0]               live;          // Tags in flight
    logic [rs_pkg::XLEN-1:0]   exp_val [16];  // Expected result per tag
    int                        errors;
    int                        cycles;
    int                        num_random;
    int                        cycle_limit;

    tomasulo_top dut_i (.*);

    always #2 clock = ~clock;

    // Result of one instruction from the opcode rules
    function automatic logic [31:0] ref_result(rs_pkg::alu_op_t o, logic [31:0] a,
                                               logic [31:0] b);
        case (o)
            rs_pkg::OP_ADD: return a + b;
            rs_pkg::OP_SUB: return a - b;
            rs_pkg::OP_AND: return a & b;
            rs_pkg::OP_OR:  return a | b;
            rs_pkg::OP_XOR: return a ^ b;
            rs_pkg::OP_SLL: return a << b[4:0];
            default:        return 32'(64'(a) * 64'(b));  // Low half of product
        endcase
    endfunction

    // Reference model on pre-edge values
    always @(posedge clock) begin
        logic [31:0] a, b;
        logic        acc;
        a   = src1_ready ? src1_value : exp_val[src1_tag];
        b   = src2_ready ? src2_value : exp_val[src2_tag];
        acc = dispatch_valid && (fu_sel == rs_pkg::FU_MULT ? mult_avail : alu_avail);
        if (reset || squash) begin
            live <= '0;  // Squashed tags must never broadcast
        end else begin
            if (cdb_valid)
                live[cdb_tag] <= 1'b0;
            if (acc) begin
                live[dest_tag]    <= 1'b1;
                exp_val[dest_tag] <= ref_result(op, a, b);
            end
        end
    end

    // Every broadcast tag must be in flight
    tag_live_chk: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> live[cdb_tag])
        else begin
            errors++;
            $display("cdb broadcast of tag %h that is not in flight", $sampled(cdb_tag));
        end

    value_chk: assert property (@(posedge clock) disable iff (reset)
        (cdb_valid && live[cdb_tag]) |-> cdb_value == exp_val[cdb_tag])
        else begin
            errors++;
            $display("error cdb_value: got %h expected %h (tag %h)", $sampled(cdb_value),
                     exp_val[$sampled(cdb_tag)], $sampled(cdb_tag));
        end

    // Quiet bus and empty station right after squash
    squash_chk: assert property (@(posedge clock) disable iff (reset)
        $past(squash) |-> (!cdb_valid && alu_avail && mult_avail))
        else begin
            errors++;
            $display("error after squash: cdb_valid %h alu_avail %h mult_avail %h, expected 0 1 1",
                     $sampled(cdb_valid), $sampled(alu_avail), $sampled(mult_avail));
        end

    // Global timeout
    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Run stopped, timeout after %0d cycles, %0d errors", cycles, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic step();
        @(posedge clock);
        #0.5;
    endtask

    task automatic dispatch(rs_pkg::fu_kind_t k, rs_pkg::alu_op_t o,
                            logic r1, logic [3:0] t1, logic [31:0] v1,
                            logic r2, logic [3:0] t2, logic [31:0] v2, logic [3:0] d);
        dispatch_valid = 1'b1;
        fu_sel         = k;
        op             = o;
        src1_ready     = r1;
        src1_tag       = t1;
        src1_value     = v1;
        src2_ready     = r2;
        src2_tag       = t2;
        src2_value     = v2;
        dest_tag       = d;
        step();          // Dispatch edge
        dispatch_valid = 1'b0;
    endtask

    // Checks the CDB cycle that follows the last edge
    task automatic check_broadcast(logic [3:0] tag);
        assert (cdb_valid && cdb_tag == tag)
        else begin
            errors++;
            $display("error cdb_tag: got %h valid %h expected %h", cdb_tag, cdb_valid, tag);
        end
    endtask

    task automatic compare_level(logic actual, logic expected, string name);
        assert (actual == expected)
        else begin
            errors++;
            $display("error %s: got %h expected %h", name, actual, expected);
        end
    endtask

    task automatic drain();
        while (live != 0)
            step();
        step();
    endtask

    task automatic random_stream(int n);
        logic [3:0] d, t1, t2;
        logic       r1, r2;
        rs_pkg::fu_kind_t k;
        rs_pkg::alu_op_t  o;
        for (int i = 0; i < n; i++) begin
            do d = 4'($urandom); while (live[d]);
            t1 = 4'($urandom);
            t2 = 4'($urandom);
            r1 = !live[t1] || ($urandom_range(0, 2) == 0);  // Pending only on live tags
            r2 = !live[t2] || ($urandom_range(0, 2) == 0);
            k  = rs_pkg::fu_kind_t'($urandom_range(0, 3) == 0);
            o  = (k == rs_pkg::FU_MULT) ? rs_pkg::OP_MUL
                                        : rs_pkg::alu_op_t'($urandom_range(0, 5));
            dispatch(k, o, r1, t1, $urandom, r2, t2, $urandom, d);
        end
        drain();
    endtask

    initial begin
        logic [31:0] a, b;
        void'($urandom(63668));
        clock          = 0;
        reset          = 1;
        squash         = 0;
        dispatch_valid = 0;
        fu_sel         = rs_pkg::FU_ALU;
        op             = rs_pkg::OP_ADD;
        src1_ready     = 0;
        src1_tag       = 0;
        src1_value     = 0;
        src2_ready     = 0;
        src2_tag       = 0;
        src2_value     = 0;
        dest_tag       = 0;
        errors         = 0;
        cycles         = 0;
        num_random     = 40;
        cycle_limit    = 60 * 6 + 12 * num_random;  // Six directed tests
        repeat (8) @(posedge clock);
        #0.5 reset = 0;
        step();
        // ALU latency for every opcode
        for (int i = 0; i < 6; i++) begin
            dispatch(rs_pkg::FU_ALU, rs_pkg::alu_op_t'(i), 1, 0, $urandom, 1, 0, $urandom,
                     4'(i + 1));
            step();
            check_broadcast(4'(i + 1));
            drain();
        end
        // Multiply latency with random operands
        a = $urandom;
        b = $urandom;
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 1, 0, a, 1, 0, b, 4'd9);
        repeat (rs_pkg::MULT_STEPS + 1) step();
        check_broadcast(4'd9);
        drain();
        // Chains with wakeup and CDB bypass
        dispatch(rs_pkg::FU_ALU, rs_pkg::OP_ADD, 1, 0, 32'h10, 1, 0, 32'h5, 4'd1);
        dispatch(rs_pkg::FU_ALU, rs_pkg::OP_SLL, 0, 4'd1, 0, 1, 0, 32'd3, 4'd2);
        dispatch(rs_pkg::FU_ALU, rs_pkg::OP_SUB, 0, 4'd1, 0, 1, 0, 32'd1, 4'd3);  // Bypass
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 0, 4'd2, 0, 0, 4'd3, 0, 4'd4);
        dispatch(rs_pkg::FU_ALU, rs_pkg::OP_XOR, 0, 4'd4, 0, 1, 0, $urandom, 4'd5);
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 0, 4'd5, 0, 0, 4'd4, 0, 4'd6);
        drain();
        // ALU entries full behind a multiply
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 1, 0, $urandom, 1, 0, $urandom, 4'd1);
        for (int i = 0; i < 4; i++)
            dispatch(rs_pkg::FU_ALU, rs_pkg::OP_OR, 0, 4'd1, 0, 1, 0, $urandom, 4'(i + 2));
        compare_level(alu_avail, 1'b0, "alu_avail");
        dispatch(rs_pkg::FU_ALU, rs_pkg::OP_ADD, 1, 0, 1, 1, 0, 2, 4'd7);  // Dropped
        while (!alu_avail)
            step();
        drain();
        // Both multiply entries full
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 1, 0, $urandom, 1, 0, $urandom, 4'd1);
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 0, 4'd1, 0, 1, 0, $urandom, 4'd2);
        compare_level(mult_avail, 1'b0, "mult_avail");
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 1, 0, 3, 1, 0, 4, 4'd3);  // Dropped
        while (!mult_avail)
            step();
        drain();
        // Squash with work in flight
        dispatch(rs_pkg::FU_MULT, rs_pkg::OP_MUL, 1, 0, $urandom, 1, 0, $urandom, 4'd1);
        dispatch(rs_pkg::FU_ALU, rs_pkg::OP_AND, 0, 4'd1, 0, 1, 0, $urandom, 4'd2);
        dispatch(rs_pkg::FU_ALU, rs_pkg::OP_ADD, 1, 0, 7, 1, 0, 8, 4'd3);
        squash = 1'b1;
        step();
        squash = 1'b0;
        repeat (12) begin
            step();
            compare_level(cdb_valid, 1'b0, "cdb_valid");
        end
        random_stream(num_random);
        $display("Checks complete, %0d errors", errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== verilog/tomasulo_top.sv ====
// Top level: station, controller, ALU and multiplier wiring
`timescale 1ns/1ps

module tomasulo_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      squash,
    input  logic                      dispatch_valid,
    input  rs_pkg::fu_kind_t          fu_sel,
    input  rs_pkg::alu_op_t           op,
    input  logic                      src1_ready,
    input  logic [rs_pkg::TAG_W-1:0]  src1_tag,
    input  logic [rs_pkg::XLEN-1:0]   src1_value,
    input  logic                      src2_ready,
    input  logic [rs_pkg::TAG_W-1:0]  src2_tag,
    input  logic [rs_pkg::XLEN-1:0]   src2_value,
    input  logic [rs_pkg::TAG_W-1:0]  dest_tag,
    output logic                      alu_avail,
    output logic                      mult_avail,
    output logic                      cdb_valid,
    output logic [rs_pkg::TAG_W-1:0]  cdb_tag,
    output logic [rs_pkg::XLEN-1:0]   cdb_value
);

    logic [rs_pkg::NUM_RS-1:0] alu_ready, mult_ready;
    logic [rs_pkg::NUM_RS-1:0] alu_grant, mult_grant;
    logic                      mult_last, mult_done;
    logic                      alu_valid;
    logic [rs_pkg::TAG_W-1:0]  alu_tag, mult_tag;
    logic [rs_pkg::XLEN-1:0]   alu_value, mult_value;

    issue_if alu_iss_bus ();
    issue_if mult_iss_bus ();

    rs u_rs (
        .clock(clock), .reset(reset), .squash(squash),
        .dispatch_valid(dispatch_valid), .fu_sel(fu_sel), .op(op),
        .src1_ready(src1_ready), .src1_tag(src1_tag), .src1_value(src1_value),
        .src2_ready(src2_ready), .src2_tag(src2_tag), .src2_value(src2_value),
        .dest_tag(dest_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .alu_grant(alu_grant), .mult_grant(mult_grant),
        .alu_ready(alu_ready), .mult_ready(mult_ready),
        .alu_avail(alu_avail), .mult_avail(mult_avail),
        .alu_iss(alu_iss_bus.source), .mult_iss(mult_iss_bus.source)
    );

    exec_ctrl u_ctrl (
        .clock(clock), .reset(reset), .squash(squash),
        .alu_ready(alu_ready), .mult_ready(mult_ready),
        .mult_last(mult_last), .mult_done(mult_done),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value),
        .mult_tag(mult_tag), .mult_value(mult_value),
        .alu_grant(alu_grant), .mult_grant(mult_grant),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
    );

    alu_unit u_alu (
        .clock(clock), .reset(reset), .squash(squash), .iss(alu_iss_bus.unit),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value)
    );

    mult_unit u_mult (
        .clock(clock), .reset(reset), .squash(squash), .iss(mult_iss_bus.unit),
        .mult_last(mult_last), .mult_done(mult_done),
        .mult_tag(mult_tag), .mult_value(mult_value)
    );

endmodule

// ==== verilog/mult_unit.sv ====
// Iterative multiplier, one 8-bit partial product per step
`timescale 1ns/1ps

module mult_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      squash,
    issue_if.unit                     iss,
    output logic                      mult_last,
    output logic                      mult_done,
    output logic [rs_pkg::TAG_W-1:0]  mult_tag,
    output logic [rs_pkg::XLEN-1:0]   mult_value
);

    logic [rs_pkg::XLEN-1:0] a_q, b_q, acc;
    logic [rs_pkg::XLEN-1:0] partial;
    logic [7:0]              slice;
    logic [1:0]              step;
    logic                    busy;

    mult_timer u_timer (
        .clock (clock),
        .reset (reset),
        .squash(squash),
        .start (iss.valid),
        .step  (step),
        .busy  (busy),
        .last  (mult_last),
        .done  (mult_done)
    );

    assign slice   = b_q[{step, 3'b000} +: 8];
    assign partial = (a_q * rs_pkg::XLEN'(slice)) << {step, 3'b000};  // Low bits only

    always_ff @(posedge clock) begin
        if (iss.valid) begin
            a_q      <= iss.opa;
            b_q      <= iss.opb;
            mult_tag <= iss.rob_tag;
            acc      <= '0;
        end else if (busy) begin
            acc <= acc + partial;
        end
    end

    assign mult_value = acc;

endmodule

// ==== verilog/mult_timer.sv ====
// Step counter sequencing the multiplier, flags last step and completion
`timescale 1ns/1ps

module mult_timer (
    input  logic       clock,
    input  logic       reset,
    input  logic       squash,
    input  logic       start,
    output logic [1:0] step,
    output logic       busy,
    output logic       last,
    output logic       done
);

    assign last = busy && (step == 2'(rs_pkg::MULT_STEPS - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            step <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else if (squash) begin
            step <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= last;           // Accumulator final one cycle later
            if (start) begin
                step <= '0;
                busy <= 1'b1;
            end else if (last) begin
                busy <= 1'b0;
            end else if (busy) begin
                step <= step + 2'd1;
            end
        end
    end

endmodule

// ==== verilog/alu_unit.sv ====
// Single-cycle ALU with registered result and tag
`timescale 1ns/1ps

module alu_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      squash,
    issue_if.unit                     iss,
    output logic                      alu_valid,
    output logic [rs_pkg::TAG_W-1:0]  alu_tag,
    output logic [rs_pkg::XLEN-1:0]   alu_value
);

    logic [rs_pkg::XLEN-1:0] result;

    always_comb begin
        case (iss.op)
            rs_pkg::OP_ADD: result = iss.opa + iss.opb;
            rs_pkg::OP_SUB: result = iss.opa - iss.opb;
            rs_pkg::OP_AND: result = iss.opa & iss.opb;
            rs_pkg::OP_OR:  result = iss.opa | iss.opb;
            rs_pkg::OP_XOR: result = iss.opa ^ iss.opb;
            rs_pkg::OP_SLL: result = iss.opa << iss.opb[4:0];  // Low 5 bits only
            default:        result = '0;                       // MUL never routed here
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            alu_valid <= 1'b0;
        else
            alu_valid <= iss.valid && !squash;
    end

    // Result payload
    always_ff @(posedge clock) begin
        if (iss.valid) begin
            alu_tag   <= iss.rob_tag;
            alu_value <= result;
        end
    end

endmodule

// ==== verilog/exec_ctrl.sv ====
// Issue controller FSM: grants, multiplier tracking, CDB mux
`timescale 1ns/1ps

module exec_ctrl (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,
    input  logic [rs_pkg::NUM_RS-1:0]  alu_ready,
    input  logic [rs_pkg::NUM_RS-1:0]  mult_ready,
    input  logic                       mult_last,
    input  logic                       mult_done,
    input  logic                       alu_valid,
    input  logic [rs_pkg::TAG_W-1:0]   alu_tag,
    input  logic [rs_pkg::XLEN-1:0]    alu_value,
    input  logic [rs_pkg::TAG_W-1:0]   mult_tag,
    input  logic [rs_pkg::XLEN-1:0]    mult_value,
    output logic [rs_pkg::NUM_RS-1:0]  alu_grant,
    output logic [rs_pkg::NUM_RS-1:0]  mult_grant,
    output logic                       cdb_valid,
    output logic [rs_pkg::TAG_W-1:0]   cdb_tag,
    output logic [rs_pkg::XLEN-1:0]    cdb_value
);

    rs_pkg::ctrl_state_t state, state_nxt;

    // Isolate the lowest set request bit
    function automatic logic [rs_pkg::NUM_RS-1:0] pick_lowest(
        input logic [rs_pkg::NUM_RS-1:0] req
    );
        return req & (~req + 1'b1);
    endfunction

    // ALU held off while the multiplier finishes, keeps the CDB free for WB
    assign alu_grant  = (squash || mult_last) ? '0 : pick_lowest(alu_ready);
    assign mult_grant = (squash || state != rs_pkg::ST_IDLE) ? '0 : pick_lowest(mult_ready);

    always_comb begin
        state_nxt = state;
        case (state)
            rs_pkg::ST_IDLE:     if (|mult_grant) state_nxt = rs_pkg::ST_MULT_RUN;
            rs_pkg::ST_MULT_RUN: if (mult_last) state_nxt = rs_pkg::ST_MULT_WB;   // Final step
            rs_pkg::ST_MULT_WB:  if (mult_done) state_nxt = rs_pkg::ST_IDLE;     // Result broadcast
            default:             state_nxt = rs_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            state <= rs_pkg::ST_IDLE;
        else if (squash)
            state <= rs_pkg::ST_IDLE;  // Abort multiply in flight
        else
            state <= state_nxt;
    end

    // CDB mux
    always_comb begin
        if (state == rs_pkg::ST_MULT_WB) begin
            cdb_valid = mult_done;
            cdb_tag   = mult_tag;
            cdb_value = mult_value;
        end else begin
            cdb_valid = alu_valid;
            cdb_tag   = alu_tag;
            cdb_value = alu_value;
        end
    end

endmodule

// ==== verilog/rs.sv ====
// Reservation station: allocation, CDB wakeup and free,
// ready vectors and operand drive onto the issue buses
`timescale 1ns/1ps

module rs (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,
    input  logic                       dispatch_valid,
    input  rs_pkg::fu_kind_t           fu_sel,
    input  rs_pkg::alu_op_t            op,
    input  logic                       src1_ready,
    input  logic [rs_pkg::TAG_W-1:0]   src1_tag,
    input  logic [rs_pkg::XLEN-1:0]    src1_value,
    input  logic                       src2_ready,
    input  logic [rs_pkg::TAG_W-1:0]   src2_tag,
    input  logic [rs_pkg::XLEN-1:0]    src2_value,
    input  logic [rs_pkg::TAG_W-1:0]   dest_tag,
    input  logic                       cdb_valid,
    input  logic [rs_pkg::TAG_W-1:0]   cdb_tag,
    input  logic [rs_pkg::XLEN-1:0]    cdb_value,
    input  logic [rs_pkg::NUM_RS-1:0]  alu_grant,
    input  logic [rs_pkg::NUM_RS-1:0]  mult_grant,
    output logic [rs_pkg::NUM_RS-1:0]  alu_ready,
    output logic [rs_pkg::NUM_RS-1:0]  mult_ready,
    output logic                       alu_avail,
    output logic                       mult_avail,
    issue_if.source                    alu_iss,
    issue_if.source                    mult_iss
);

    rs_pkg::rs_entry_t entry [rs_pkg::NUM_RS];
    rs_pkg::rs_entry_t new_entry;               // Entry built from dispatch
    logic                          alloc_en;
    logic [rs_pkg::RS_ID_W-1:0]    alloc_id;
    logic [rs_pkg::NUM_RS-1:0]     free_vec;
    logic [rs_pkg::NUM_RS-1:0]     ready_vec;

    // Per-entry status
    always_comb begin
        for (int i = 0; i < rs_pkg::NUM_RS; i++) begin
            free_vec[i]  = !entry[i].busy;
            ready_vec[i] = entry[i].busy && !entry[i].issued
                           && entry[i].src1_valid && entry[i].src2_valid;
        end
    end

    assign alu_ready  = ready_vec & rs_pkg::ALU_MASK;
    assign mult_ready = ready_vec & ~rs_pkg::ALU_MASK;
    assign alu_avail  = |(free_vec & rs_pkg::ALU_MASK);
    assign mult_avail = |(free_vec & ~rs_pkg::ALU_MASK);

    // Lowest free slot of the requested kind, scanned top down
    always_comb begin
        alloc_en = 1'b0;
        alloc_id = '0;
        for (int i = rs_pkg::NUM_RS - 1; i >= 0; i--) begin
            if (free_vec[i] && ((fu_sel == rs_pkg::FU_MULT) == (i >= rs_pkg::NUM_ALU_RS))) begin
                alloc_en = dispatch_valid;
                alloc_id = rs_pkg::RS_ID_W'(i);
            end
        end
    end

    // Sources not ready at dispatch may still catch the CDB this cycle
    always_comb begin
        new_entry            = '0;
        new_entry.busy       = 1'b1;
        new_entry.op         = op;
        new_entry.dest_tag   = dest_tag;
        new_entry.src1_tag   = src1_tag;
        new_entry.src1_valid = src1_ready || (cdb_valid && cdb_tag == src1_tag);
        new_entry.src1_value = src1_ready ? src1_value : cdb_value;
        new_entry.src2_tag   = src2_tag;
        new_entry.src2_valid = src2_ready || (cdb_valid && cdb_tag == src2_tag);
        new_entry.src2_value = src2_ready ? src2_value : cdb_value;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rs_pkg::NUM_RS; i++) begin
                entry[i].busy       <= 1'b0;
                entry[i].issued     <= 1'b0;
                entry[i].src1_valid <= 1'b0;
                entry[i].src2_valid <= 1'b0;
            end
        end else if (squash) begin
            for (int i = 0; i < rs_pkg::NUM_RS; i++) begin
                entry[i].busy       <= 1'b0;
                entry[i].issued     <= 1'b0;
                entry[i].src1_valid <= 1'b0;
                entry[i].src2_valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rs_pkg::NUM_RS; i++) begin
                if (cdb_valid && entry[i].busy && entry[i].dest_tag == cdb_tag) begin
                    entry[i].busy   <= 1'b0;  // Own result broadcast, free
                    entry[i].issued <= 1'b0;
                end else begin
                    // Wakeup of waiting sources
                    if (cdb_valid && !entry[i].src1_valid && entry[i].src1_tag == cdb_tag) begin
                        entry[i].src1_value <= cdb_value;
                        entry[i].src1_valid <= 1'b1;
                    end
                    if (cdb_valid && !entry[i].src2_valid && entry[i].src2_tag == cdb_tag) begin
                        entry[i].src2_value <= cdb_value;
                        entry[i].src2_valid <= 1'b1;
                    end
                    if (alu_grant[i] || mult_grant[i])
                        entry[i].issued <= 1'b1;
                end
                // Only free slots are allocated, so no clash with the above
                if (alloc_en && alloc_id == rs_pkg::RS_ID_W'(i))
                    entry[i] <= new_entry;
            end
        end
    end

    // Operand mux for the one-hot grants
    always_comb begin
        alu_iss.valid     = |alu_grant;
        alu_iss.entry_id  = '0;
        alu_iss.op        = rs_pkg::OP_ADD;
        alu_iss.opa       = '0;
        alu_iss.opb       = '0;
        alu_iss.rob_tag   = '0;
        mult_iss.valid    = |mult_grant;
        mult_iss.entry_id = '0;
        mult_iss.op       = rs_pkg::OP_MUL;
        mult_iss.opa      = '0;
        mult_iss.opb      = '0;
        mult_iss.rob_tag  = '0;
        for (int i = 0; i < rs_pkg::NUM_RS; i++) begin
            if (alu_grant[i]) begin
                alu_iss.entry_id = rs_pkg::RS_ID_W'(i);
                alu_iss.op       = entry[i].op;
                alu_iss.opa      = entry[i].src1_value;
                alu_iss.opb      = entry[i].src2_value;
                alu_iss.rob_tag  = entry[i].dest_tag;
            end
            if (mult_grant[i]) begin
                mult_iss.entry_id = rs_pkg::RS_ID_W'(i);
                mult_iss.op       = entry[i].op;
                mult_iss.opa      = entry[i].src1_value;
                mult_iss.opb      = entry[i].src2_value;
                mult_iss.rob_tag  = entry[i].dest_tag;
            end
        end
    end

endmodule

// ==== verilog/issue_if.sv ====
// Issue bus from the reservation station to one execution unit
`timescale 1ns/1ps

interface issue_if;

    logic                         valid;     // One-cycle strobe with the grant
    logic [rs_pkg::RS_ID_W-1:0]   entry_id;
    rs_pkg::alu_op_t              op;
    logic [rs_pkg::XLEN-1:0]      opa;
    logic [rs_pkg::XLEN-1:0]      opb;
    logic [rs_pkg::TAG_W-1:0]     rob_tag;

    modport source (
        output valid, entry_id, op, opa, opb, rob_tag
    );

    modport unit (
        input valid, entry_id, op, opa, opb, rob_tag
    );

endinterface

// ==== verilog/rs_pkg.sv ====
// Shared sizes, unit-kind / opcode / controller enums
// and the reservation station entry struct
package rs_pkg;

    localparam int XLEN       = 32;
    localparam int TAG_W      = 4;   // ROB tag width
    localparam int NUM_RS     = 6;
    localparam int NUM_ALU_RS = 4;   // Entries 0..3 ALU, rest multiplier
    localparam int RS_ID_W    = 3;
    localparam int MULT_STEPS = 4;   // One step per byte of opb

    // Slots owned by the ALU
    localparam logic [NUM_RS-1:0] ALU_MASK = NUM_RS'((1 << NUM_ALU_RS) - 1);

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_kind_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_MUL
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,      // Multiplier free
        ST_MULT_RUN,  // Multiplier stepping
        ST_MULT_WB    // Multiplier owns the CDB
    } ctrl_state_t;

    typedef struct packed {
        logic             busy;
        logic             issued;
        alu_op_t          op;
        logic [TAG_W-1:0] src1_tag;
        logic [XLEN-1:0]  src1_value;
        logic             src1_valid;
        logic [TAG_W-1:0] src2_tag;
        logic [XLEN-1:0]  src2_value;
        logic             src2_valid;
        logic [TAG_W-1:0] dest_tag;   // Result tag this entry waits to see
    } rs_entry_t;

endpackage
